// File: adc_frontend.sv
module adc_frontend import rp_dsp_pkg::*; (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  // raw converter pins
  input  logic [ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [ADC_PIN_W-1:0] adc_dat_b_i,
  // digital loopback
  input  logic                 loop_en_i,
  input  chan_pair_t           loop_i,      // registered sums from the dac side
  output chan_pair_t           sample_o
);

  ////////////////////////////////////////////////////////////
  // input register
  ////////////////////////////////////////////////////////////

  chan_pair_t adc_q;  // signed samples, one cycle after the pins
  code_t      pin_a;
  code_t      pin_b;

  // upper 14 pin bits carry the code, bits 1:0 are dead
  assign pin_a = adc_dat_a_i[ADC_PIN_W-1 -: SAMPLE_W];
  assign pin_b = adc_dat_b_i[ADC_PIN_W-1 -: SAMPLE_W];

  // IO register, slope flip folded into the d input
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      adc_q <= '0;  // zero sample
    end
    else
    begin
      adc_q.a <= code_to_sample(pin_a);  // ch1
      adc_q.b <= code_to_sample(pin_b);  // ch2
    end
  end

  ////////////////////////////////////////////////////////////
  // loopback select
  ////////////////////////////////////////////////////////////

  // both channels switch together
  // loop_i already comes from a register so no extra stage here
  assign sample_o = loop_en_i ? loop_i : adc_q;

endmodule

// File: dac_offset_stage.sv
module dac_offset_stage import rp_bus_pkg::*, rp_dsp_pkg::*; (
  input  logic       adc_clk,
  input  logic       rst_n_i,
  // bus region 0
  input  sys_req_t   req_i,
  output sys_rsp_t   rsp_o,
  // sample path
  input  chan_pair_t sample_i,
  output chan_pair_t sum_o,       // registered, also fed back for loopback
  output code_pair_t dac_code_o   // to dac pins
);

  sample_t           ofs_a;      // manual offset ch1
  sample_t           ofs_b;      // manual offset ch2
  dsp_reg_e          reg_ofs;
  logic              strobe;
  logic              in_window;  // address bits between offset and region are zero
  logic              mapped;
  logic [BUS_DW-1:0] rd_val;
  logic              ack_q;
  logic              err_q;
  logic [BUS_DW-1:0] rdata_q;
  sum_t              sum_a;
  sum_t              sum_b;

  function automatic sample_t saturate(input sum_t v);
    if (v > SAMPLE_MAX)
      return sample_t'(SAMPLE_MAX);
    else if (v < SAMPLE_MIN)
      return sample_t'(SAMPLE_MIN);
    return sample_t'(v);
  endfunction

  ////////////////////////////////////////////////////////////
  // bus side
  ////////////////////////////////////////////////////////////

  assign strobe    = req_i.wen | req_i.ren;
  assign reg_ofs   = dsp_reg_e'(req_i.addr[REG_OFS_W-1:0]);
  assign in_window = (req_i.addr[REGION_LSB-1:REG_OFS_W] == '0);

  always_comb
  begin
    rd_val = '0;
    mapped = in_window;
    case (reg_ofs)
      OFS_A:   rd_val = {{(BUS_DW-SAMPLE_W){ofs_a[SAMPLE_W-1]}}, ofs_a};  // sign extended
      OFS_B:   rd_val = {{(BUS_DW-SAMPLE_W){ofs_b[SAMPLE_W-1]}}, ofs_b};
      default: mapped = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      ofs_a <= '0;
      ofs_b <= '0;
    end
    else
    begin
      ack_q <= strobe;            // always one cycle later
      err_q <= strobe & ~mapped;
      if (req_i.wen && mapped && reg_ofs == OFS_A)
      begin
        if (req_i.sel[0]) ofs_a[7:0] <= req_i.wdata[7:0];
        if (req_i.sel[1]) ofs_a[SAMPLE_W-1:8] <= req_i.wdata[SAMPLE_W-1:8];
      end
      if (req_i.wen && mapped && reg_ofs == OFS_B)
      begin
        if (req_i.sel[0]) ofs_b[7:0] <= req_i.wdata[7:0];
        if (req_i.sel[1]) ofs_b[SAMPLE_W-1:8] <= req_i.wdata[SAMPLE_W-1:8];
      end
    end
  end

  // read data, zero on writes and errors
  always_ff @(posedge adc_clk)
  begin
    if (strobe)
      rdata_q <= (req_i.ren && mapped) ? rd_val : '0;
  end

  assign rsp_o = '{rdata: rdata_q, err: err_q, ack: ack_q};

  ////////////////////////////////////////////////////////////
  // sample side
  ////////////////////////////////////////////////////////////

  assign sum_a = sum_t'(sample_i.a) + sum_t'(ofs_a);  // cannot overflow 15 bits
  assign sum_b = sum_t'(sample_i.b) + sum_t'(ofs_b);

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      sum_o      <= '0;
      dac_code_o <= '{a: CODE_ZERO, b: CODE_ZERO};  // mid code, not 0
    end
    else
    begin
      sum_o.a      <= saturate(sum_a);
      sum_o.b      <= saturate(sum_b);
      dac_code_o.a <= sample_to_code(sum_o.a);  // output register
      dac_code_o.b <= sample_to_code(sum_o.b);
    end
  end

endmodule

// File: housekeeping_regs.sv
module housekeeping_regs import rp_bus_pkg::*; (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  // bus region 3
  input  sys_req_t         req_i,
  output sys_rsp_t         rsp_o,
  // expansion connector
  input  logic [EXP_W-1:0] exp_p_dat_i,
  input  logic [EXP_W-1:0] exp_n_dat_i,
  output logic [EXP_W-1:0] exp_p_dat_o,
  output logic [EXP_W-1:0] exp_n_dat_o,
  output logic [EXP_W-1:0] exp_p_dir_o,  // 1 = drive
  output logic [EXP_W-1:0] exp_n_dir_o,
  // misc
  output logic [LED_W-1:0] led_o,
  output logic             loop_en_o
);

  logic [EXP_W-1:0]  exp_p_meta;
  logic [EXP_W-1:0]  exp_n_meta;
  logic [EXP_W-1:0]  exp_p_sync;
  logic [EXP_W-1:0]  exp_n_sync;
  hk_reg_e           reg_ofs;
  logic              strobe;
  logic              mapped;
  logic              read_only;
  logic              acc_err;
  logic [BUS_DW-1:0] rd_val;
  logic              ack_q;
  logic              err_q;
  logic [BUS_DW-1:0] rdata_q;

  // pins are async to adc_clk, two flop sync
  always_ff @(posedge adc_clk)
  begin
    exp_p_meta <= exp_p_dat_i;
    exp_n_meta <= exp_n_dat_i;
    exp_p_sync <= exp_p_meta;
    exp_n_sync <= exp_n_meta;
  end

  ////////////////////////////////////////////////////////////
  // register decode
  ////////////////////////////////////////////////////////////

  assign strobe    = req_i.wen | req_i.ren;
  assign reg_ofs   = hk_reg_e'(req_i.addr[REG_OFS_W-1:0]);
  assign read_only = (reg_ofs == HK_ID) || (reg_ofs == HK_EXP_P_IN) || (reg_ofs == HK_EXP_N_IN);
  assign acc_err   = ~mapped | (req_i.wen & read_only);  // bad offset or write to ro

  always_comb
  begin
    rd_val = '0;
    mapped = (req_i.addr[REGION_LSB-1:REG_OFS_W] == '0);
    case (reg_ofs)
      HK_ID:        rd_val = HK_ID_VALUE;
      HK_EXP_P_DIR: rd_val = BUS_DW'(exp_p_dir_o);
      HK_EXP_N_DIR: rd_val = BUS_DW'(exp_n_dir_o);
      HK_EXP_P_OUT: rd_val = BUS_DW'(exp_p_dat_o);
      HK_EXP_N_OUT: rd_val = BUS_DW'(exp_n_dat_o);
      HK_EXP_P_IN:  rd_val = BUS_DW'(exp_p_sync);  // synced copy
      HK_EXP_N_IN:  rd_val = BUS_DW'(exp_n_sync);
      HK_LED:       rd_val = BUS_DW'(led_o);
      HK_LOOP:      rd_val = BUS_DW'(loop_en_o);
      default:      mapped = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ack_q       <= 1'b0;
      err_q       <= 1'b0;
      exp_p_dir_o <= '0;  // all inputs
      exp_n_dir_o <= '0;
      exp_p_dat_o <= '0;
      exp_n_dat_o <= '0;
      led_o       <= '0;
      loop_en_o   <= 1'b0;
    end
    else
    begin
      ack_q <= strobe;
      err_q <= strobe & acc_err;
      // every writable reg fits in byte lane 0
      if (req_i.wen && !acc_err && req_i.sel[0])
      begin
        case (reg_ofs)
          HK_EXP_P_DIR: exp_p_dir_o <= req_i.wdata[EXP_W-1:0];
          HK_EXP_N_DIR: exp_n_dir_o <= req_i.wdata[EXP_W-1:0];
          HK_EXP_P_OUT: exp_p_dat_o <= req_i.wdata[EXP_W-1:0];
          HK_EXP_N_OUT: exp_n_dat_o <= req_i.wdata[EXP_W-1:0];
          HK_LED:       led_o       <= req_i.wdata[LED_W-1:0];
          HK_LOOP:      loop_en_o   <= req_i.wdata[0];  // bit 0 only
          default:      ;
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (strobe)
      rdata_q <= (req_i.ren && !acc_err) ? rd_val : '0;
  end

  assign rsp_o = '{rdata: rdata_q, err: err_q, ack: ack_q};

endmodule

// File: rp_bus_pkg.sv
package rp_bus_pkg;

  ////////////////////////////////////////////////////////////
  // system bus geometry
  ////////////////////////////////////////////////////////////

  localparam int BUS_AW      = 32;
  localparam int BUS_DW      = 32;
  localparam int BUS_SW      = BUS_DW / 8;  // one sel bit per byte lane
  localparam int NUM_REGIONS = 8;
  localparam int REGION_LSB  = 20;          // region field sits at addr[22:20]
  localparam int REGION_W    = 3;
  localparam int REG_OFS_W   = 8;           // register offset inside a region

  // housekeeping widths
  localparam int EXP_W = 8;   // expansion connector, per side
  localparam int LED_W = 8;
  localparam logic [BUS_DW-1:0] HK_ID_VALUE = 32'h5250_1a01;  // board id word

  // request from the master, held until ack
  typedef struct packed {
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] wdata;
    logic [BUS_SW-1:0] sel;   // byte enables, writes only
    logic              wen;   // one cycle strobe
    logic              ren;   // one cycle strobe
  } sys_req_t;

  // slave answer, valid for the single ack cycle
  typedef struct packed {
    logic [BUS_DW-1:0] rdata;
    logic              err;
    logic              ack;
  } sys_rsp_t;

  typedef enum logic [REGION_W-1:0] {
    REGION_DSP = 3'd0,  // dac offset regs
    REGION_HK  = 3'd3   // housekeeping
  } bus_region_e;

  // regions with a real slave behind them, the rest get a dummy ack
  localparam logic [NUM_REGIONS-1:0] REGION_USED =
    (NUM_REGIONS'(1) << REGION_DSP) | (NUM_REGIONS'(1) << REGION_HK);

  typedef enum logic [REG_OFS_W-1:0] {
    OFS_A = 8'h00,
    OFS_B = 8'h04
  } dsp_reg_e;

  typedef enum logic [REG_OFS_W-1:0] {
    HK_ID        = 8'h00,
    HK_EXP_P_DIR = 8'h10,
    HK_EXP_N_DIR = 8'h14,
    HK_EXP_P_OUT = 8'h18,
    HK_EXP_N_OUT = 8'h1C,
    HK_EXP_P_IN  = 8'h20,
    HK_EXP_N_IN  = 8'h24,
    HK_LED       = 8'h30,
    HK_LOOP      = 8'h40
  } hk_reg_e;

endpackage

// File: rp_dsp_pkg.sv
package rp_dsp_pkg;

  ////////////////////////////////////////////////////////////
  // sample formats
  ////////////////////////////////////////////////////////////

  localparam int ADC_PIN_W = 16;  // two lsbs not driven by the 14 bit part
  localparam int SAMPLE_W  = 14;

  typedef logic signed [SAMPLE_W-1:0] sample_t;   // two's complement
  typedef logic signed [SAMPLE_W:0]   sum_t;      // one guard bit for the add
  typedef logic        [SAMPLE_W-1:0] code_t;     // converter offset code

  typedef struct packed {
    sample_t a;
    sample_t b;
  } chan_pair_t;

  typedef struct packed {
    code_t a;
    code_t b;
  } code_pair_t;

  // clamp limits, held in sum width for direct compare
  localparam sum_t  SAMPLE_MAX = 15'sd8191;
  localparam sum_t  SAMPLE_MIN = -15'sd8192;
  localparam code_t CODE_ZERO  = 14'h1fff;    // code of a zero sample

  // converters have negative slope, msb kept and the rest inverted
  function automatic sample_t code_to_sample(input code_t c);
    return sample_t'({c[SAMPLE_W-1], ~c[SAMPLE_W-2:0]});
  endfunction

  function automatic code_t sample_to_code(input sample_t s);
    return code_t'({s[SAMPLE_W-1], ~s[SAMPLE_W-2:0]});
  endfunction

endpackage

// File: rp_lite_chk.sv
module rp_lite_chk import rp_bus_pkg::*; (
  input logic             adc_clk,
  input logic             rst_n_i,
  input sys_req_t         sys_req_i,
  input sys_rsp_t         sys_rsp_i,
  input logic [LED_W-1:0] led_i,
  input logic [EXP_W-1:0] exp_p_dir_i,
  input logic [EXP_W-1:0] exp_n_dir_i
);

  logic strobe;

  assign strobe = sys_req_i.wen | sys_req_i.ren;

  ////////////////////////////////////////////////////////////
  // bus handshake
  ////////////////////////////////////////////////////////////

  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    strobe |=> sys_rsp_i.ack)
    else $error("no ack one cycle after a bus strobe");

  // single strobe cycle, so this also bounds ack to one cycle
  ack_needs_strobe: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_rsp_i.ack |-> $past(strobe))
    else $error("ack raised without a strobe in the cycle before");

  // state right after a reset edge
  reset_state: assert property (@(posedge adc_clk)
    !rst_n_i |=> (!sys_rsp_i.ack && !sys_rsp_i.err && led_i == '0 &&
                  exp_p_dir_i == '0 && exp_n_dir_i == '0))
    else $error("ack, err, leds or directions not cleared by reset");

endmodule

bind rp_lite_top rp_lite_chk u_rp_lite_chk (
  .adc_clk     (adc_clk),
  .rst_n_i     (rst_n_i),
  .sys_req_i   (sys_req_i),
  .sys_rsp_i   (sys_rsp_o),
  .led_i       (led_o),
  .exp_p_dir_i (exp_p_dir_o),
  .exp_n_dir_i (exp_n_dir_o)
);

// File: rp_lite_testdata.txt
# W addr data sel err | R addr data err | A pin_a pin_b | E p_in n_in | N count
# C led p_dir n_dir p_out n_out | L loopback run | all values hex
C 0 0 0 0 0
A 7ffc 7ffc
A 0000 fffc
A 8003 5a5b
N 20
R 00000000 00000000 0
W 00000000 00000064 f 0
W 00000004 fffffe0c f 0
R 00000004 fffffe0c 0
A 0003 ffff
A 9000 6000
N 20
W 00000000 0000ff12 1 0
R 00000000 00000012 0
W 00000004 00001500 2 0
R 00000004 0000150c 0
W 00000008 0000ffff f 1
R 00000008 00000000 1
W 00000100 0000ffff f 1
R 00000000 00000012 0
A 4000 c000
R 00300000 52501a01 0
W 00300000 00000000 f 1
W 00300030 000000a5 f 0
W 00300010 0000003c f 0
W 00300014 000000c3 f 0
W 00300018 00000011 f 0
W 0030001c 00000022 e 0
C a5 3c c3 11 00
R 00300030 000000a5 0
R 0030001c 00000000 0
W 00300044 00000001 f 1
R 00300040 00000000 0
W 00100000 ffffffff f 0
W 00700030 ffffffff f 0
R 00500004 00000000 0
C a5 3c c3 11 00
E 5a a5
R 00300020 0000005a 0
R 00300024 000000a5 0
W 00300020 00000000 f 1
W 00000000 00000000 f 0
W 00000004 00000000 f 0
A 7ffc 7ffc
W 00300040 00000001 1 0
W 00000000 000003e8 3 0
W 00000004 fffffc18 3 0
L
W 00300040 00000000 1 0
A 7ffc 7ffc

// File: rp_lite_top.sv
module rp_lite_top import rp_bus_pkg::*, rp_dsp_pkg::*; (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  // ADC
  input  logic [ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [ADC_PIN_W-1:0] adc_dat_b_i,
  // DAC
  output code_t                dac_dat_a_o,
  output code_t                dac_dat_b_o,
  // system bus
  input  sys_req_t             sys_req_i,
  output sys_rsp_t             sys_rsp_o,
  // expansion connector
  input  logic [EXP_W-1:0]     exp_p_dat_i,
  input  logic [EXP_W-1:0]     exp_n_dat_i,
  output logic [EXP_W-1:0]     exp_p_dat_o,
  output logic [EXP_W-1:0]     exp_n_dat_o,
  output logic [EXP_W-1:0]     exp_p_dir_o,
  output logic [EXP_W-1:0]     exp_n_dir_o,
  // LED
  output logic [LED_W-1:0]     led_o
);

  sys_req_t   dsp_req;
  sys_rsp_t   dsp_rsp;
  sys_req_t   hk_req;
  sys_rsp_t   hk_rsp;
  chan_pair_t adc_sample;  // after loopback mux
  chan_pair_t dsp_sum;     // saturated sums, loop source
  code_pair_t dac_code;
  logic       loop_en;

  assign dac_dat_a_o = dac_code.a;
  assign dac_dat_b_o = dac_code.b;

  ////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////

  sys_bus_decoder u_sys_bus_decoder (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .req_i     (sys_req_i),
    .rsp_o     (sys_rsp_o),
    .dsp_req_o (dsp_req),    // region 0
    .dsp_rsp_i (dsp_rsp),
    .hk_req_o  (hk_req),     // region 3
    .hk_rsp_i  (hk_rsp)
  );

  adc_frontend u_adc_frontend (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (loop_en),
    .loop_i      (dsp_sum),
    .sample_o    (adc_sample)
  );

  dac_offset_stage u_dac_offset_stage (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .req_i      (dsp_req),
    .rsp_o      (dsp_rsp),
    .sample_i   (adc_sample),
    .sum_o      (dsp_sum),
    .dac_code_o (dac_code)
  );

  housekeeping_regs u_housekeeping_regs (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .req_i       (hk_req),
    .rsp_o       (hk_rsp),
    .exp_p_dat_i (exp_p_dat_i),
    .exp_n_dat_i (exp_n_dat_i),
    .exp_p_dat_o (exp_p_dat_o),
    .exp_n_dat_o (exp_n_dat_o),
    .exp_p_dir_o (exp_p_dir_o),
    .exp_n_dir_o (exp_n_dir_o),
    .led_o       (led_o),
    .loop_en_o   (loop_en)    // back to the frontend mux
  );

endmodule

// File: run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module tb_rp_lite -o tb_rp_lite \
  && ./obj_dir/tb_rp_lite | tee /dev/stderr | grep -qx "NO ERRORS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sources.f
rp_bus_pkg.sv
rp_dsp_pkg.sv
adc_frontend.sv
dac_offset_stage.sv
housekeeping_regs.sv
sys_bus_decoder.sv
rp_lite_top.sv
rp_lite_chk.sv
tb_rp_lite.sv

// File: sys_bus_decoder.sv
module sys_bus_decoder import rp_bus_pkg::*; (
  input  logic     adc_clk,
  input  logic     rst_n_i,
  // master side
  input  sys_req_t req_i,
  output sys_rsp_t rsp_o,
  // region 0
  output sys_req_t dsp_req_o,
  input  sys_rsp_t dsp_rsp_i,
  // region 3
  output sys_req_t hk_req_o,
  input  sys_rsp_t hk_rsp_i
);

  bus_region_e            region;
  logic [NUM_REGIONS-1:0] cs;          // one hot chip select
  logic                   strobe;
  logic                   idle_hit;    // access lands in an unused region
  logic                   idle_ack_q;

  ////////////////////////////////////////////////////////////
  // chip select and strobe gating
  ////////////////////////////////////////////////////////////

  assign region = bus_region_e'(req_i.addr[REGION_LSB +: REGION_W]);
  assign cs     = NUM_REGIONS'(1) << req_i.addr[REGION_LSB +: REGION_W];
  assign strobe = req_i.wen | req_i.ren;

  // address, data and sel go everywhere, only the strobes are gated
  always_comb
  begin
    dsp_req_o     = req_i;
    dsp_req_o.wen = req_i.wen & cs[REGION_DSP];
    dsp_req_o.ren = req_i.ren & cs[REGION_DSP];
    hk_req_o      = req_i;
    hk_req_o.wen  = req_i.wen & cs[REGION_HK];
    hk_req_o.ren  = req_i.ren & cs[REGION_HK];
  end

  ////////////////////////////////////////////////////////////
  // unused regions
  ////////////////////////////////////////////////////////////

  assign idle_hit = !(|(cs & REGION_USED));

  // registered so the dummy ack has the same one cycle latency
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      idle_ack_q <= 1'b0;
    else
      idle_ack_q <= strobe & idle_hit;
  end

  // response mux, addr is still held when the ack comes back
  always_comb
  begin
    case (region)
      REGION_DSP: rsp_o = dsp_rsp_i;
      REGION_HK:  rsp_o = hk_rsp_i;
      default:    rsp_o = '{rdata: {BUS_DW{1'b0}}, err: 1'b0, ack: idle_ack_q};
    endcase
  end

endmodule

// File: tb_rp_lite.sv
module tb_rp_lite import rp_bus_pkg::*, rp_dsp_pkg::*; ();

  // one parsed line of the stimulus file
  typedef struct packed {
    logic [7:0]       op;
    logic [4:0][31:0] arg;
  } cmd_t;

  logic                 adc_clk;
  logic                 rst_n_i;
  logic [ADC_PIN_W-1:0] adc_dat_a_i;
  logic [ADC_PIN_W-1:0] adc_dat_b_i;
  code_t                dac_dat_a_o;
  code_t                dac_dat_b_o;
  sys_req_t             sys_req_i;
  sys_rsp_t             sys_rsp_o;
  logic [EXP_W-1:0]     exp_p_dat_i;
  logic [EXP_W-1:0]     exp_n_dat_i;
  logic [EXP_W-1:0]     exp_p_dat_o;
  logic [EXP_W-1:0]     exp_n_dat_o;
  logic [EXP_W-1:0]     exp_p_dir_o;
  logic [EXP_W-1:0]     exp_n_dir_o;
  logic [LED_W-1:0]     led_o;

  cmd_t                cmds [$];
  int                  num_cmds;
  int                  mism_cnt;
  int                  fail_cnt;
  logic [SAMPLE_W-1:0] ofs_m [2];  // mirror of the two offset regs

  rp_lite_top u_rp_lite_top (.*);

  initial
  begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;  // 20 unit period
  end

  ////////////////////////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////////////////////////

  // inverted slope code with msb kept
  function automatic code_t to_code(input int s);
    logic [SAMPLE_W-1:0] v;
    v = s[SAMPLE_W-1:0];
    return {v[SAMPLE_W-1], ~v[SAMPLE_W-2:0]};
  endfunction

  function automatic code_t expected_code(input logic [ADC_PIN_W-1:0] pin,
                                          input logic [SAMPLE_W-1:0] ofs);
    logic [SAMPLE_W-1:0] raw;
    int                  s;
    raw = {pin[15], ~pin[14:2]};  // bits 1:0 ignored
    s = int'($signed(raw)) + int'($signed(ofs));
    if (s > int'(SAMPLE_MAX))
      s = int'(SAMPLE_MAX);
    else if (s < int'(SAMPLE_MIN))
      s = int'(SAMPLE_MIN);
    return to_code(s);
  endfunction

  function automatic int arg_count(input logic [7:0] op);
    case (op)
      "W":     return 4;
      "C":     return 5;
      "R":     return 3;
      "A":     return 2;
      "E":     return 2;
      "N":     return 1;
      default: return 0;
    endcase
  endfunction

  // region field plus register offset
  function automatic logic [31:0] reg_addr(input logic [REGION_W-1:0] region,
                                           input logic [REG_OFS_W-1:0] ofs);
    return (32'(region) << REGION_LSB) | 32'(ofs);
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
      mism_cnt++;
    end
  endtask

  // region 0 offset regs use byte lanes 0 and 1 only
  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] sel);
    int ch;
    if (addr[REGION_LSB +: REGION_W] == REGION_DSP && addr[REGION_LSB-1:REG_OFS_W] == '0 &&
        (addr[7:0] == OFS_A || addr[7:0] == OFS_B))
    begin
      ch = (addr[7:0] == OFS_B) ? 1 : 0;
      if (sel[0]) ofs_m[ch][7:0] = data[7:0];
      if (sel[1]) ofs_m[ch][SAMPLE_W-1:8] = data[SAMPLE_W-1:8];
    end
  endtask

  ////////////////////////////////////////////////////////////
  // drivers
  ////////////////////////////////////////////////////////////

  task automatic bus_access(input bit is_wr, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] sel, output logic [31:0] rdata, output logic err);
    int waited;
    waited = 0;
    rdata  = '0;
    err    = 1'b0;
    @(posedge adc_clk);
    sys_req_i.addr  <= addr;
    sys_req_i.wdata <= data;
    sys_req_i.sel   <= sel;
    sys_req_i.wen   <= is_wr;
    sys_req_i.ren   <= !is_wr;
    @(posedge adc_clk);
    sys_req_i.wen <= 1'b0;  // single cycle strobe while addr stays
    sys_req_i.ren <= 1'b0;
    @(negedge adc_clk);
    while (!sys_rsp_o.ack && waited < 4)
    begin
      @(negedge adc_clk);
      waited++;
    end
    if (!sys_rsp_o.ack)
    begin
      $display("Bus access to address %h got no ack within 4 cycles", addr);
      fail_cnt++;
    end
    else
    begin
      compare_value($sformatf("ack delay at %h", addr), 32'd0, waited);
      rdata = sys_rsp_o.rdata;
      err   = sys_rsp_o.err;
    end
  endtask

  // register read back that must not error
  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] exp_v);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b0, addr, 32'd0, 4'hf, rdata, err);
    compare_value({name, " rdata"}, exp_v, rdata);
    compare_value({name, " err"}, 32'd0, 32'(err));
  endtask

  task automatic apply_pins(input logic [ADC_PIN_W-1:0] pa, input logic [ADC_PIN_W-1:0] pb,
                            input string tag);
    @(posedge adc_clk);
    adc_dat_a_i <= pa;
    adc_dat_b_i <= pb;
    repeat (3) @(posedge adc_clk);  // frontend, sum, code reg
    @(negedge adc_clk);
    compare_value({tag, " dac a"}, 32'(expected_code(pa, ofs_m[0])), 32'(dac_dat_a_o));
    compare_value({tag, " dac b"}, 32'(expected_code(pb, ofs_m[1])), 32'(dac_dat_b_o));
  endtask

  // back to back samples checked 3 cycles later
  task automatic random_stream(input int n, input string tag);
    logic [ADC_PIN_W-1:0] pa;
    logic [ADC_PIN_W-1:0] pb;
    code_t                want_a [$];
    code_t                want_b [$];
    for (int j = 0; j < n + 3; j++)
    begin
      @(posedge adc_clk);
      if (j < n)
      begin
        pa = 16'($urandom);
        pb = 16'($urandom);
        adc_dat_a_i <= pa;
        adc_dat_b_i <= pb;
        want_a.push_back(expected_code(pa, ofs_m[0]));
        want_b.push_back(expected_code(pb, ofs_m[1]));
      end
      @(negedge adc_clk);
      if (j >= 3)
      begin
        compare_value($sformatf("%s sample %0d a", tag, j - 3), 32'(want_a.pop_front()),
                      32'(dac_dat_a_o));
        compare_value($sformatf("%s sample %0d b", tag, j - 3), 32'(want_b.pop_front()),
                      32'(dac_dat_b_o));
      end
    end
  endtask

  // sum feeds back and climbs by the offset each cycle
  task automatic loopback_run(input string tag);
    int    ofs_v [2];
    int    lim [2];
    int    last;
    code_t target [2];
    code_t act [2];
    last = 0;
    for (int ch = 0; ch < 2; ch++)
    begin
      ofs_v[ch] = int'($signed(ofs_m[ch]));
      if (ofs_v[ch] == 0)
      begin
        $display("Loopback run %s has a zero offset on channel %0d", tag, ch);
        fail_cnt++;
        return;
      end
      lim[ch]    = 8192 / (ofs_v[ch] > 0 ? ofs_v[ch] : -ofs_v[ch]) + 4;
      target[ch] = to_code(ofs_v[ch] > 0 ? int'(SAMPLE_MAX) : int'(SAMPLE_MIN));
      if (lim[ch] > last) last = lim[ch];
    end
    for (int cyc = 1; cyc <= last + 8; cyc++)  // keep watching past the bound
    begin
      @(negedge adc_clk);
      act[0] = dac_dat_a_o;
      act[1] = dac_dat_b_o;
      for (int ch = 0; ch < 2; ch++)
        if (cyc >= lim[ch])
          compare_value($sformatf("%s ch %0d cycle %0d", tag, ch, cyc), 32'(target[ch]),
                        32'(act[ch]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int          fd;
    int          rc;
    int          ch;
    bit          eof;
    logic [7:0]  op;
    logic [31:0] v;
    logic [31:0] rdata;
    logic        err;
    cmd_t        c;
    string       tag;
    mism_cnt    = 0;
    fail_cnt    = 0;
    num_cmds    = 0;
    ofs_m[0]    = '0;
    ofs_m[1]    = '0;
    rst_n_i     <= 1'b0;
    sys_req_i   <= '0;
    adc_dat_a_i <= '0;
    adc_dat_b_i <= '0;
    exp_p_dat_i <= '0;
    exp_n_dat_i <= '0;
    void'($urandom(32'h2fe4));
    fd = $fopen("rp_lite_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open rp_lite_testdata.txt");
      fail_cnt++;
    end
    else
    begin
      eof = 1'b0;
      while (!eof)
      begin
        rc = $fscanf(fd, " %c", op);
        if (rc != 1)
          eof = 1'b1;
        else if (op == "#")
        begin
          ch = $fgetc(fd);  // drop the rest of a comment line
          while (ch != 10 && ch != -1)
            ch = $fgetc(fd);
        end
        else
        begin
          c    = '0;
          c.op = op;
          for (int k = 0; k < arg_count(op); k++)
          begin
            rc       = $fscanf(fd, "%h", v);
            c.arg[k] = v;
          end
          cmds.push_back(c);
        end
      end
      $fclose(fd);
    end
    num_cmds = cmds.size();  // arms the watchdog
    repeat (3) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    @(negedge adc_clk);
    compare_value("reset dac a", 32'(to_code(0)), 32'(dac_dat_a_o));  // mid code
    compare_value("reset dac b", 32'(to_code(0)), 32'(dac_dat_b_o));
    foreach (cmds[i])
    begin
      c   = cmds[i];
      tag = $sformatf("cmd %0d %c", i, c.op);
      case (c.op)
        "W":
        begin
          bus_access(1'b1, c.arg[0], c.arg[1], c.arg[2][3:0], rdata, err);
          compare_value({tag, " err"}, c.arg[3], 32'(err));
          model_write(c.arg[0], c.arg[1], c.arg[2][3:0]);
        end
        "R":
        begin
          bus_access(1'b0, c.arg[0], 32'd0, 4'hf, rdata, err);
          compare_value({tag, " rdata"}, c.arg[1], rdata);
          compare_value({tag, " err"}, c.arg[2], 32'(err));
        end
        "A": apply_pins(c.arg[0][ADC_PIN_W-1:0], c.arg[1][ADC_PIN_W-1:0], tag);
        "E":
        begin
          @(posedge adc_clk);
          exp_p_dat_i <= c.arg[0][EXP_W-1:0];
          exp_n_dat_i <= c.arg[1][EXP_W-1:0];
          repeat (3) @(posedge adc_clk);  // through the sync flops
        end
        "C":
        begin
          @(negedge adc_clk);
          compare_value({tag, " led"}, c.arg[0], 32'(led_o));
          compare_value({tag, " p dir"}, c.arg[1], 32'(exp_p_dir_o));
          compare_value({tag, " n dir"}, c.arg[2], 32'(exp_n_dir_o));
          compare_value({tag, " p out"}, c.arg[3], 32'(exp_p_dat_o));
          compare_value({tag, " n out"}, c.arg[4], 32'(exp_n_dat_o));
          // the same registers read back over the bus
          read_check({tag, " led rd"}, reg_addr(REGION_HK, HK_LED), c.arg[0]);
          read_check({tag, " p dir rd"}, reg_addr(REGION_HK, HK_EXP_P_DIR), c.arg[1]);
          read_check({tag, " n dir rd"}, reg_addr(REGION_HK, HK_EXP_N_DIR), c.arg[2]);
          read_check({tag, " p out rd"}, reg_addr(REGION_HK, HK_EXP_P_OUT), c.arg[3]);
          read_check({tag, " n out rd"}, reg_addr(REGION_HK, HK_EXP_N_OUT), c.arg[4]);
          // offsets follow the write model, sign extended
          read_check({tag, " ofs a rd"}, reg_addr(REGION_DSP, OFS_A),
                     32'(int'($signed(ofs_m[0]))));
          read_check({tag, " ofs b rd"}, reg_addr(REGION_DSP, OFS_B),
                     32'(int'($signed(ofs_m[1]))));
        end
        "L": loopback_run(tag);
        "N": random_stream(int'(c.arg[0]), tag);
        default:
        begin
          $display("Unknown command %c in rp_lite_testdata.txt", c.op);
          fail_cnt++;
        end
      endcase
    end
    $display("run complete: %0d commands, %0d mismatches, %0d other errors",
             num_cmds, mism_cnt, fail_cnt);
    if (mism_cnt + fail_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // 40 cycles per command is far above the longest one
  initial
  begin
    wait (num_cmds > 0);
    #(num_cmds * 40 * 20 + 2000);
    $display("Watchdog timeout, the command list did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule
